// ==== bp_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_asserts
    import bp_pred_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire pred_req_t  pred_req,
    input  wire pred_rsp_t  pred_rsp
);

    // every request answered exactly one cycle later
    rsp_after_req: assert property (
        @(posedge clk) disable iff (!rstn)
        pred_req.valid |=> pred_rsp.valid
    ) else $error("no response one cycle after a request");

    // no response without a request
    no_spurious_rsp: assert property (
        @(posedge clk) disable iff (!rstn)
        !pred_req.valid |=> !pred_rsp.valid
    ) else $error("response valid without a request in the previous cycle");

    // stalled fetch holds its pc
    stall_holds_pc: assert property (
        @(posedge clk) disable iff (!rstn)
        (pred_req.valid && pred_req.stall) |=> (pred_rsp.npc == $past(pred_req.pc))
    ) else $error("stalled request did not return its own pc");

endmodule

`default_nettype wire

// ==== bp_cfg.svh ====
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// word address width, byte offset bits dropped
`define ADDR_WIDTH 30

// index width of btb and cpht, 64 entries each
`define IDX_WIDTH 6

// return address stack depth
`define STACK_LEN 8

// response pc out of reset
// the 32-bit boot word is cut down to a 30-bit word address
`define RESET_PC `ADDR_WIDTH'(32'h7000_0002)

`endif

// ==== bp_pred_pkg.sv ====
`default_nettype none

`include "bp_cfg.svh"

package bp_pred_pkg;

    import bp_upd_pkg::*;

    // branch kind from predecode
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } br_kind_t;

    // fetch side request
    typedef struct packed {
        logic                    valid;
        logic                    stall;
        // taken hint from predecode
        logic                    taken;
        br_kind_t                kind;
        logic [`ADDR_WIDTH-1:0]  pc;
        logic [`IDX_WIDTH-1:0]   ghist;
    } pred_req_t;

    // prediction returned one cycle after the request
    typedef struct packed {
        logic                    valid;
        logic [`ADDR_WIDTH-1:0]  npc;
        logic                    use_ras;
        choice_cnt_t             cnt;
    } pred_rsp_t;

endpackage

`default_nettype wire

// ==== bp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module bp_top
    import bp_pred_pkg::*, bp_upd_pkg::*;
(
    input  wire                 clk,
    input  wire                 rstn,
    input  wire pred_req_t      pred_req,
    input  wire bp_update_t     upd,
    output pred_rsp_t           pred_rsp
);

    logic [`IDX_WIDTH-1:0]  btb_idx;
    logic [`IDX_WIDTH-1:0]  cpht_idx;
    logic [`ADDR_WIDTH-1:0] btb_target;
    logic [`ADDR_WIDTH-1:0] ras_top;
    choice_cnt_t            cnt;

    // selector, reads all three tables
    npc_predictor u_npc (
        .clk        (clk),
        .rstn       (rstn),
        .req        (pred_req),
        .btb_idx    (btb_idx),
        .cpht_idx   (cpht_idx),
        .btb_target (btb_target),
        .ras_top    (ras_top),
        .cnt        (cnt),
        .rsp        (pred_rsp)
    );

    // tables, trained only by committed updates
    btb u_btb (
        .clk    (clk),
        .rd_idx (btb_idx),
        .target (btb_target),
        .upd    (upd)
    );

    ras u_ras (
        .clk    (clk),
        .rstn   (rstn),
        .upd    (upd),
        .top    (ras_top)
    );

    cpht u_cpht (
        .clk    (clk),
        .rstn   (rstn),
        .rd_idx (cpht_idx),
        .cnt    (cnt),
        .upd    (upd)
    );

endmodule

`default_nettype wire

// ==== bp_upd_pkg.sv ====
`default_nettype none

`include "bp_cfg.svh"

package bp_upd_pkg;

    // 2-bit ras/btb choice counter, msb set means take the ras
    typedef logic [1:0] choice_cnt_t;

    // weakly btb after reset
    localparam choice_cnt_t CNT_INIT = 2'b01;
    localparam choice_cnt_t CNT_MAX  = 2'b11;
    localparam choice_cnt_t CNT_MIN  = 2'b00;

    // committed branch from execute, one per strobe
    typedef struct packed {
        logic                    valid;
        // same encoding as br_kind_t in bp_pred_pkg
        logic [2:0]              kind;
        logic [`ADDR_WIDTH-1:0]  pc;
        logic [`IDX_WIDTH-1:0]   ghist;
        logic [`ADDR_WIDTH-1:0]  target;
        // return address pushed on a call
        logic [`ADDR_WIDTH-1:0]  ret_pc;
        // resolved outcome, ras was the right source
        logic                    use_ras_real;
        // counter value read at prediction time
        choice_cnt_t             cnt;
    } bp_update_t;

endpackage

`default_nettype wire

// ==== btb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module btb
    import bp_pred_pkg::*, bp_upd_pkg::*;
(
    input  wire                     clk,
    input  wire [`IDX_WIDTH-1:0]    rd_idx,
    output logic [`ADDR_WIDTH-1:0]  target,
    input  wire bp_update_t         upd
);

    localparam int DEPTH = 1 << `IDX_WIDTH;

    // no tags, aliasing entries just share a slot
    logic [`ADDR_WIDTH-1:0] target_mem [DEPTH];

    logic [`IDX_WIDTH-1:0]  wr_idx;
    logic                   wr_en;

    // same hash as the read side, pc xor history
    assign wr_idx = upd.pc[`IDX_WIDTH-1:0] ^ upd.ghist;

    // any real branch teaches its target
    assign wr_en = upd.valid && (upd.kind != NOT_JUMP);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            target_mem[wr_idx] <= upd.target;
        end
    end

    // combinational read, sees a write from the previous edge
    assign target = target_mem[rd_idx];

endmodule

`default_nettype wire

// ==== cpht.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module cpht
    import bp_pred_pkg::*, bp_upd_pkg::*;
(
    input  wire                     clk,
    input  wire                     rstn,
    input  wire [`IDX_WIDTH-1:0]    rd_idx,
    output choice_cnt_t             cnt,
    input  wire bp_update_t         upd
);

    localparam int DEPTH = 1 << `IDX_WIDTH;

    choice_cnt_t cnt_mem [DEPTH];

    logic [`IDX_WIDTH-1:0]  wr_idx;
    logic                   wr_en;
    choice_cnt_t            cnt_next;

    // indexed by pc alone, no history
    assign wr_idx = upd.pc[`IDX_WIDTH-1:0];

    // only returns train the choice
    assign wr_en = upd.valid && (upd.kind == RET);

    // saturating step on the counter carried back by the update
    always_comb begin
        cnt_next = upd.cnt;
        if (upd.use_ras_real) begin
            if (upd.cnt != CNT_MAX) begin
                cnt_next = upd.cnt + 1'b1;
            end
        end else begin
            if (upd.cnt != CNT_MIN) begin
                cnt_next = upd.cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt_mem[i] <= CNT_INIT;
            end
        end else if (wr_en) begin
            cnt_mem[wr_idx] <= cnt_next;
        end
    end

    assign cnt = cnt_mem[rd_idx];

endmodule

`default_nettype wire

// ==== npc_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module npc_predictor
    import bp_pred_pkg::*, bp_upd_pkg::*;
(
    input  wire                     clk,
    input  wire                     rstn,
    input  wire pred_req_t          req,
    output logic [`IDX_WIDTH-1:0]   btb_idx,
    output logic [`IDX_WIDTH-1:0]   cpht_idx,
    input  wire [`ADDR_WIDTH-1:0]   btb_target,
    input  wire [`ADDR_WIDTH-1:0]   ras_top,
    input  wire choice_cnt_t        cnt,
    output pred_rsp_t               rsp
);

    logic [`ADDR_WIDTH-1:0] step;
    logic [`ADDR_WIDTH-1:0] seq_pc;
    logic [`ADDR_WIDTH-1:0] npc;
    logic                   use_ras;

    // table indices
    assign btb_idx  = req.pc[`IDX_WIDTH-1:0] ^ req.ghist;
    assign cpht_idx = req.pc[`IDX_WIDTH-1:0];

    // even pc steps over a pair, odd pc finishes it
    assign step   = req.pc[0] ? `ADDR_WIDTH'(1) : `ADDR_WIDTH'(2);
    assign seq_pc = req.pc + step;

    // counter msb picks the ras for returns
    assign use_ras = cnt[1];

    always_comb begin
        npc = seq_pc;
        if (req.stall) begin
            npc = req.pc;
        end else if (req.taken) begin
            case (req.kind)
                DIRECT_JUMP,
                INDIRECT_JUMP,
                CALL,
                JUMP: begin
                    npc = btb_target;
                end
                RET: begin
                    npc = use_ras ? ras_top : btb_target;
                end
                default: begin
                    npc = seq_pc;
                end
            endcase
        end
    end

    // one cycle from request to response
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rsp.valid   <= 1'b0;
            rsp.npc     <= `RESET_PC;
            rsp.use_ras <= 1'b0;
            rsp.cnt     <= CNT_INIT;
        end else begin
            rsp.valid <= req.valid;
            // payload holds between requests
            if (req.valid) begin
                rsp.npc     <= npc;
                rsp.use_ras <= use_ras;
                rsp.cnt     <= cnt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== ras.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module ras
    import bp_pred_pkg::*, bp_upd_pkg::*;
(
    input  wire                     clk,
    input  wire                     rstn,
    input  wire bp_update_t         upd,
    output logic [`ADDR_WIDTH-1:0]  top
);

    localparam int PW = (`STACK_LEN > 1) ? $clog2(`STACK_LEN) : 1;
    localparam logic [PW-1:0] LAST = PW'(`STACK_LEN - 1);
    localparam logic [PW:0]   FULL = (PW + 1)'(`STACK_LEN);

    logic [`ADDR_WIDTH-1:0] stack_mem [`STACK_LEN];

    // ptr is the next free slot
    logic [PW-1:0]  ptr;
    logic [PW-1:0]  ptr_inc;
    logic [PW-1:0]  ptr_dec;
    // number of live entries
    logic [PW:0]    fill;

    logic push;
    logic pop;

    // only committed calls and returns move the stack
    assign push = upd.valid && (upd.kind == CALL);
    assign pop  = upd.valid && (upd.kind == RET);

    // circular wrap for any depth
    assign ptr_inc = (ptr == LAST) ? '0 : ptr + 1'b1;
    assign ptr_dec = (ptr == '0) ? LAST : ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr  <= '0;
            fill <= '0;
        end else if (push) begin
            ptr <= ptr_inc;
            // full stack overwrites its oldest entry
            if (fill != FULL) begin
                fill <= fill + 1'b1;
            end
        end else if (pop && (fill != '0)) begin
            ptr  <= ptr_dec;
            fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[ptr] <= upd.ret_pc;
        end
    end

    // most recent push, meaningless while empty
    assign top = stack_mem[ptr_dec];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_bp -Mdir obj_dir -o tb_bp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+.
bp_upd_pkg.sv
bp_pred_pkg.sv
btb.sv
ras.sv
cpht.sv
npc_predictor.sv
bp_top.sv
bp_asserts.sv
tb_bp.sv

// ==== tb_bp.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module tb_bp
    import bp_pred_pkg::*, bp_upd_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int RSP_TIMEOUT  = 8;
    // rough cycle budget of each test, in run order
    localparam int TEST_CYCLES  = 8 + 20 + 12 + 30 + 70;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 200) * CLK_PERIOD;

    logic       clk;
    logic       rstn;
    pred_req_t  pred_req;
    bp_update_t upd;
    pred_rsp_t  pred_rsp;

    string cur_test;
    int    test_errs;
    int    tests_passed;
    int    tests_failed;

    // expected stack contents, oldest first
    logic [`ADDR_WIDTH-1:0] ras_model[$];

    // return site whose choice counter gets trained up
    logic [`ADDR_WIDTH-1:0] ret_site_pc;
    logic [`IDX_WIDTH-1:0]  ret_site_gh;

    bp_top DUT (
        .clk      (clk),
        .rstn     (rstn),
        .pred_req (pred_req),
        .upd      (upd),
        .pred_rsp (pred_rsp)
    );

    bind bp_top bp_asserts u_asserts (
        .clk      (clk),
        .rstn     (rstn),
        .pred_req (pred_req),
        .pred_rsp (pred_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [`ADDR_WIDTH-1:0] rand_addr();
        return `ADDR_WIDTH'($urandom());
    endfunction

    function automatic logic [`IDX_WIDTH-1:0] rand_idx();
        return `IDX_WIDTH'($urandom());
    endfunction

    function automatic pred_req_t make_req(input logic stall, input logic taken,
                                           input br_kind_t kind,
                                           input logic [`ADDR_WIDTH-1:0] pc,
                                           input logic [`IDX_WIDTH-1:0] ghist);
        pred_req_t r;
        r.valid = 1'b1;
        r.stall = stall;
        r.taken = taken;
        r.kind  = kind;
        r.pc    = pc;
        r.ghist = ghist;
        return r;
    endfunction

    function automatic bp_update_t make_upd(input br_kind_t kind,
                                            input logic [`ADDR_WIDTH-1:0] pc,
                                            input logic [`IDX_WIDTH-1:0] ghist,
                                            input logic [`ADDR_WIDTH-1:0] target,
                                            input logic [`ADDR_WIDTH-1:0] ret_pc,
                                            input logic use_ras_real,
                                            input choice_cnt_t cnt);
        bp_update_t u;
        u.valid        = 1'b1;
        u.kind         = kind;
        u.pc           = pc;
        u.ghist        = ghist;
        u.target       = target;
        u.ret_pc       = ret_pc;
        u.use_ras_real = use_ras_real;
        u.cnt          = cnt;
        return u;
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", cur_test, test_errs);
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // one committed update, strobed for a single cycle
    task automatic send_upd(input bp_update_t u);
        @(posedge clk);
        upd <= u;
        @(posedge clk);
        upd.valid <= 1'b0;
        if (u.kind == CALL) begin
            ras_model.push_back(u.ret_pc);
            if (ras_model.size() > `STACK_LEN) begin
                void'(ras_model.pop_front());
            end
        end else if (u.kind == RET && ras_model.size() > 0) begin
            void'(ras_model.pop_back());
        end
    endtask

    // single request, then wait for its response
    task automatic predict(input pred_req_t r, output pred_rsp_t rsp);
        int waited;
        waited = 0;
        @(posedge clk);
        pred_req <= r;
        @(posedge clk);
        pred_req.valid <= 1'b0;
        @(negedge clk);
        while (!pred_rsp.valid && waited < RSP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (pred_rsp.valid) else begin
            $display("test %s: DUT gave no response to a request", cur_test);
            test_errs++;
        end
        rsp = pred_rsp;
    endtask

    task automatic test_reset_seq();
        logic [`ADDR_WIDTH-1:0] pc_even;
        logic [`ADDR_WIDTH-1:0] pc_odd;
        logic [`ADDR_WIDTH-1:0] exp_pc;
        start_test("reset_seq");
        @(negedge clk);
        check_val("valid after reset", 32'd0, 32'(pred_rsp.valid));
        check_val("npc after reset", 32'(`RESET_PC), 32'(pred_rsp.npc));
        pc_even    = rand_addr();
        pc_even[0] = 1'b0;
        pc_odd     = rand_addr();
        pc_odd[0]  = 1'b1;
        // back to back, fixed one cycle latency
        @(posedge clk);
        pred_req <= make_req(1'b0, 1'b0, NOT_JUMP, pc_even, rand_idx());
        @(posedge clk);
        pred_req <= make_req(1'b0, 1'b0, NOT_JUMP, pc_odd, rand_idx());
        @(negedge clk);
        exp_pc = pc_even + 2'd2;
        check_val("even valid", 32'd1, 32'(pred_rsp.valid));
        check_val("even npc", 32'(exp_pc), 32'(pred_rsp.npc));
        @(posedge clk);
        pred_req.valid <= 1'b0;
        @(negedge clk);
        exp_pc = pc_odd + 1'b1;
        check_val("odd valid", 32'd1, 32'(pred_rsp.valid));
        check_val("odd npc", 32'(exp_pc), 32'(pred_rsp.npc));
        @(negedge clk);
        check_val("idle valid", 32'd0, 32'(pred_rsp.valid));
        end_test();
    endtask

    task automatic test_btb_learn();
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`IDX_WIDTH-1:0]  gh_a;
        logic [`IDX_WIDTH-1:0]  gh_b;
        logic [`ADDR_WIDTH-1:0] tgt_a;
        logic [`ADDR_WIDTH-1:0] tgt_b;
        pred_rsp_t              rsp;
        start_test("btb_learn");
        pc    = rand_addr();
        gh_a  = rand_idx();
        // one flipped history bit lands on another entry
        gh_b  = gh_a ^ `IDX_WIDTH'(1);
        tgt_a = rand_addr();
        tgt_b = rand_addr();
        send_upd(make_upd(DIRECT_JUMP, pc, gh_a, tgt_a, '0, 1'b0, CNT_INIT));
        predict(make_req(1'b0, 1'b1, DIRECT_JUMP, pc, gh_a), rsp);
        check_val("target a", 32'(tgt_a), 32'(rsp.npc));
        send_upd(make_upd(DIRECT_JUMP, pc, gh_b, tgt_b, '0, 1'b0, CNT_INIT));
        predict(make_req(1'b0, 1'b1, JUMP, pc, gh_b), rsp);
        check_val("target b", 32'(tgt_b), 32'(rsp.npc));
        predict(make_req(1'b0, 1'b1, INDIRECT_JUMP, pc, gh_a), rsp);
        check_val("target a kept", 32'(tgt_a), 32'(rsp.npc));
        end_test();
    endtask

    task automatic test_stall();
        logic [`ADDR_WIDTH-1:0] pc;
        pred_rsp_t              rsp;
        start_test("stall");
        pc = rand_addr();
        predict(make_req(1'b1, 1'b1, JUMP, pc, rand_idx()), rsp);
        check_val("stall jump", 32'(pc), 32'(rsp.npc));
        predict(make_req(1'b1, 1'b1, RET, pc, rand_idx()), rsp);
        check_val("stall ret", 32'(pc), 32'(rsp.npc));
        predict(make_req(1'b1, 1'b0, NOT_JUMP, pc, rand_idx()), rsp);
        check_val("stall seq", 32'(pc), 32'(rsp.npc));
        end_test();
    endtask

    task automatic test_ret_choice();
        logic [`ADDR_WIDTH-1:0] tgt;
        logic [`ADDR_WIDTH-1:0] call_pc;
        pred_rsp_t              rsp;
        start_test("ret_choice");
        ret_site_pc = rand_addr();
        ret_site_gh = rand_idx();
        call_pc     = rand_addr();
        for (int i = 0; i < 3; i++) begin
            send_upd(make_upd(CALL, call_pc, rand_idx(), rand_addr(), rand_addr(),
                              1'b0, CNT_INIT));
        end
        tgt = rand_addr();
        send_upd(make_upd(DIRECT_JUMP, ret_site_pc, ret_site_gh, tgt, '0, 1'b0, CNT_INIT));
        // fresh counter 01 keeps the btb
        predict(make_req(1'b0, 1'b1, RET, ret_site_pc, ret_site_gh), rsp);
        check_val("fresh npc", 32'(tgt), 32'(rsp.npc));
        check_val("fresh use_ras", 32'd0, 32'(rsp.use_ras));
        check_val("fresh cnt", 32'(2'b01), 32'(rsp.cnt));
        send_upd(make_upd(RET, ret_site_pc, ret_site_gh, tgt, '0, 1'b1, rsp.cnt));
        predict(make_req(1'b0, 1'b1, RET, ret_site_pc, ret_site_gh), rsp);
        check_val("one up cnt", 32'(2'b10), 32'(rsp.cnt));
        check_val("one up use_ras", 32'd1, 32'(rsp.use_ras));
        check_val("one up npc", 32'(ras_model[$]), 32'(rsp.npc));
        send_upd(make_upd(RET, ret_site_pc, ret_site_gh, tgt, '0, 1'b1, rsp.cnt));
        predict(make_req(1'b0, 1'b1, RET, ret_site_pc, ret_site_gh), rsp);
        check_val("two up cnt", 32'(2'b11), 32'(rsp.cnt));
        check_val("two up use_ras", 32'd1, 32'(rsp.use_ras));
        check_val("two up npc", 32'(ras_model[$]), 32'(rsp.npc));
        // drain the last entry for the next test
        send_upd(make_upd(RET, ret_site_pc, ret_site_gh, tgt, '0, 1'b1, CNT_MAX));
        end_test();
    endtask

    task automatic test_ras_order();
        logic [`ADDR_WIDTH-1:0] call_pc;
        pred_rsp_t              rsp;
        start_test("ras_order");
        call_pc = rand_addr();
        for (int i = 0; i < `STACK_LEN + 2; i++) begin
            send_upd(make_upd(CALL, call_pc, rand_idx(), rand_addr(), rand_addr(),
                              1'b0, CNT_INIT));
        end
        // saturated counter at the return site, so npc shows the stack top
        while (ras_model.size() > 0) begin
            predict(make_req(1'b0, 1'b1, RET, ret_site_pc, ret_site_gh), rsp);
            check_val("ras entry", 32'(ras_model[$]), 32'(rsp.npc));
            send_upd(make_upd(RET, ret_site_pc, ret_site_gh, rand_addr(), '0,
                              1'b1, CNT_MAX));
        end
        end_test();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h31605286));
        pred_req     = '0;
        upd          = '0;
        rstn         = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        test_reset_seq();
        test_btb_learn();
        test_stall();
        test_ret_choice();
        test_ras_order();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
